// File: aluExecute.sv
//////////////////////////////////////////////////
// single-cycle ops finish in one clock; MUL and DIV
// block the stage until the multi-cycle unit is done
//////////////////////////////////////////////////
`default_nettype none

`include "alu_defs.svh"

module aluExecute (
	input  wire                      clk,
	input  wire                      arstN,
	input  wire                      issValid,
	input  wire aluOpPkg::aluReqT    issReq,
	output logic                     issTake,
	output logic                     exValid,
	output aluResultPkg::aluRespT    exResp,
	input  wire                      exTake
);

	localparam int W   = `ALU_WIDTH;
	localparam int SHW = $clog2(`ALU_WIDTH);

	logic                      issFire;
	logic                      isMd;
	logic                      exFree;
	logic                      mdStart;
	logic                      mdIsDiv;
	logic                      mdBusy;
	logic                      mdDone;
	logic                      mdHeld;
	logic                      mdHave;
	logic                      mdLoad;
	logic                      mdDivZero;
	logic [W-1:0]              mdHi;
	logic [W-1:0]              mdLo;
	logic [`ALU_TAG_BITS-1:0]  pendTag;
	aluResultPkg::mdStateE     pendState;
	aluResultPkg::aluRespT     scResp;
	aluResultPkg::aluRespT     mdResp;
	logic [SHW-1:0]            shAmt;
	logic                      bigShift;
	logic [W-1:0]              shraRes;
	logic [2*W-1:0]            rorWide;
	logic [2*W-1:0]            rolWide;

	assign issFire = issValid && issTake;
	assign isMd    = (issReq.op == aluOpPkg::opMul) || (issReq.op == aluOpPkg::opDiv);
	assign mdIsDiv = (issReq.op == aluOpPkg::opDiv);
	assign exFree  = !exValid || exTake;
	assign mdStart = issFire && isMd;

	// no new op while a MUL/DIV is running or its result waits
	assign issTake = (pendState == aluResultPkg::mdIdle) && !mdBusy && exFree;

	// done is a pulse, the result may have to wait for a free register
	assign mdHave = mdDone || mdHeld;
	assign mdLoad = (pendState != aluResultPkg::mdIdle) && mdHave && exFree;

	// shifts of 32 or more saturate, rotates wrap on the low bits
	assign shAmt    = issReq.b[SHW-1:0];
	assign bigShift = |issReq.b[W-1:SHW];
	assign shraRes  = $signed(issReq.a) >>> shAmt;
	assign rorWide  = {issReq.a, issReq.a} >> shAmt;
	assign rolWide  = {issReq.a, issReq.a} << shAmt;

	always_comb begin
		scResp     = '0;
		scResp.tag = issReq.tag;
		case (issReq.op)
			aluOpPkg::opAdd:   scResp.lo = issReq.a + issReq.b;
			aluOpPkg::opSub:   scResp.lo = issReq.a - issReq.b;
			aluOpPkg::opAnd:   scResp.lo = issReq.a & issReq.b;
			aluOpPkg::opOr:    scResp.lo = issReq.a | issReq.b;
			aluOpPkg::opShr:   scResp.lo = bigShift ? '0 : issReq.a >> shAmt;
			aluOpPkg::opShl:   scResp.lo = bigShift ? '0 : issReq.a << shAmt;
			aluOpPkg::opShra:  scResp.lo = bigShift ? {W{issReq.a[W-1]}} : shraRes;
			aluOpPkg::opRor:   scResp.lo = rorWide[W-1:0];
			aluOpPkg::opRol:   scResp.lo = rolWide[2*W-1:W];
			aluOpPkg::opNeg:   scResp.lo = -issReq.b;
			aluOpPkg::opNot:   scResp.lo = ~issReq.b;
			aluOpPkg::opIncPc: scResp.lo = issReq.b + 1'b1;
			// unknown code, lo stays zero
			default:           scResp.status.badOp = 1'b1;
		endcase
	end

	// MUL/DIV result, both halves written back
	always_comb begin
		mdResp                = '0;
		mdResp.hi             = mdHi;
		mdResp.lo             = mdLo;
		mdResp.writeHi        = 1'b1;
		mdResp.status.divZero = (pendState == aluResultPkg::mdDiv) && mdDivZero;
		mdResp.tag            = pendTag;
	end

	aluMulDiv i_mulDiv (
		.clk     (clk),
		.arstN   (arstN),
		.start   (mdStart),
		.isDiv   (mdIsDiv),
		.a       (issReq.a),
		.b       (issReq.b),
		.busy    (mdBusy),
		.done    (mdDone),
		.hi      (mdHi),
		.lo      (mdLo),
		.divZero (mdDivZero)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exValid   <= 1'b0;
			mdHeld    <= 1'b0;
			pendState <= aluResultPkg::mdIdle;
		end else begin
			if ((issFire && !isMd) || mdLoad)
				exValid <= 1'b1;
			else if (exTake)
				exValid <= 1'b0;

			if (mdLoad)
				mdHeld <= 1'b0;
			else if (mdDone)
				mdHeld <= 1'b1;

			// remember which unit op is in flight
			if (mdStart)
				pendState <= mdIsDiv ? aluResultPkg::mdDiv : aluResultPkg::mdMul;
			else if (mdLoad)
				pendState <= aluResultPkg::mdIdle;
		end
	end

	always_ff @(posedge clk) begin
		if (mdStart)
			pendTag <= issReq.tag;
		if (issFire && !isMd)
			exResp <= scResp;
		else if (mdLoad)
			exResp <= mdResp;
	end

endmodule

`default_nettype wire

// File: aluIssue.sv
//////////////////////////////////////////////////
// four-phase input side, inOp must hold while inReq
// is high; one-entry issue register
//////////////////////////////////////////////////
`default_nettype none

`include "alu_defs.svh"

module aluIssue (
	input  wire                  clk,
	input  wire                  arstN,
	input  wire                  inReq,
	input  wire aluOpPkg::aluReqT inOp,
	output logic                 inAck,
	output logic                 issValid,
	output aluOpPkg::aluReqT     issReq,
	input  wire                  issTake
);

	// handshake phases seen from the ALU
	typedef enum logic {
		inIdle,
		inAckd
	} inStateE;

	inStateE inState;
	logic    canLoad;
	logic    capture;

	// register free now, or freed by execute on this edge
	assign canLoad = !issValid || issTake;

	// accept only from idle so each request is taken once
	assign capture = (inState == inIdle) && inReq && canLoad;

	// ack follows the state register, rises a cycle after the capture
	assign inAck = (inState == inAckd);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			inState  <= inIdle;
			issValid <= 1'b0;
		end else begin
			case (inState)
				inIdle: begin
					if (capture)
						inState <= inAckd;
				end
				inAckd: begin
					// source released the request, close the exchange
					if (!inReq)
						inState <= inIdle;
				end
				default: inState <= inIdle;
			endcase

			if (capture)
				issValid <= 1'b1;
			else if (issTake)
				issValid <= 1'b0;
		end
	end

	// payload, only loaded on capture
	always_ff @(posedge clk) begin
		if (capture)
			issReq <= inOp;
	end

endmodule

`default_nettype wire

// File: aluMulDiv.sv
//////////////////////////////////////////////////
// signed MUL, 16 Booth steps; signed DIV, 32 steps
// plus sign fix; hi/lo hold until the next start
//////////////////////////////////////////////////
`default_nettype none

`include "alu_defs.svh"

module aluMulDiv (
	input  wire                   clk,
	input  wire                   arstN,
	input  wire                   start,
	input  wire                   isDiv,
	input  wire [`ALU_WIDTH-1:0]  a,
	input  wire [`ALU_WIDTH-1:0]  b,
	output logic                  busy,
	output logic                  done,
	output logic [`ALU_WIDTH-1:0] hi,
	output logic [`ALU_WIDTH-1:0] lo,
	output logic                  divZero
);

	localparam int W  = `ALU_WIDTH;
	localparam int CW = $clog2(`DIV_STEPS) + 1;

	aluResultPkg::mdStateE state;
	logic [CW-1:0]         cnt;
	// product, or quotient in the low half while dividing
	logic [2*W-1:0]        acc;
	// sign-extended multiplicand, moves up two bits per step
	logic [2*W-1:0]        mcand;
	// multiplier with the implied zero below bit 0
	logic [W:0]            mq;
	// signed partial remainder
	logic [W:0]            rem;
	logic [W-1:0]          dvsr;
	logic                  negQ;
	logic                  negR;
	logic                  bZero;
	logic [W-1:0]          absA;
	logic [W-1:0]          absB;
	logic [2*W-1:0]        boothPart;
	logic [W:0]            remShift;
	logic [W:0]            remNext;
	logic [W:0]            remRestored;
	logic                  mulLast;
	logic                  divLast;

	assign busy    = (state != aluResultPkg::mdIdle);
	assign hi      = acc[2*W-1:W];
	assign lo      = acc[W-1:0];
	assign bZero   = (b == '0);
	assign absA    = a[W-1] ? -a : a;
	assign absB    = b[W-1] ? -b : b;
	assign mulLast = (cnt == CW'(`MUL_STEPS - 1));
	assign divLast = (cnt == CW'(`DIV_STEPS - 1));

	// radix-4 recoding of three multiplier bits
	always_comb begin
		case (mq[2:0])
			3'b001, 3'b010: boothPart = mcand;
			3'b011:         boothPart = mcand << 1;
			3'b100:         boothPart = -(mcand << 1);
			3'b101, 3'b110: boothPart = -mcand;
			default:        boothPart = '0;
		endcase
	end

	// non-restoring step, sign of the old remainder picks add or subtract
	assign remShift    = {rem[W-1:0], acc[W-1]};
	assign remNext     = rem[W] ? remShift + {1'b0, dvsr} : remShift - {1'b0, dvsr};
	assign remRestored = remNext[W] ? remNext + {1'b0, dvsr} : remNext;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state   <= aluResultPkg::mdIdle;
			cnt     <= '0;
			done    <= 1'b0;
			divZero <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				aluResultPkg::mdIdle: begin
					if (start) begin
						cnt     <= '0;
						divZero <= isDiv && bZero;
						// zero divisor goes straight to the fix state
						if (!isDiv)
							state <= aluResultPkg::mdMul;
						else if (bZero)
							state <= aluResultPkg::mdFix;
						else
							state <= aluResultPkg::mdDiv;
					end
				end
				aluResultPkg::mdMul: begin
					cnt <= cnt + 1'b1;
					if (mulLast) begin
						state <= aluResultPkg::mdIdle;
						done  <= 1'b1;
					end
				end
				aluResultPkg::mdDiv: begin
					cnt <= cnt + 1'b1;
					if (divLast)
						state <= aluResultPkg::mdFix;
				end
				aluResultPkg::mdFix: begin
					state <= aluResultPkg::mdIdle;
					done  <= 1'b1;
				end
				default: state <= aluResultPkg::mdIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			aluResultPkg::mdIdle: begin
				if (start) begin
					mcand <= {{W{a[W-1]}}, a};
					mq    <= {b, 1'b0};
					dvsr  <= absB;
					// divide by zero leaves the dividend as remainder
					rem   <= (isDiv && bZero) ? {1'b0, a} : '0;
					acc   <= (isDiv && !bZero) ? {{W{1'b0}}, absA} : '0;
					negQ  <= a[W-1] ^ b[W-1];
					// remainder follows the dividend sign
					negR  <= a[W-1] && !bZero;
				end
			end
			aluResultPkg::mdMul: begin
				acc   <= acc + boothPart;
				mcand <= mcand << 2;
				mq    <= {{2{mq[W]}}, mq[W:2]};
			end
			aluResultPkg::mdDiv: begin
				rem          <= divLast ? remRestored : remNext;
				acc[W-1:0]   <= {acc[W-2:0], ~remNext[W]};
			end
			aluResultPkg::mdFix: begin
				// most negative / -1 wraps through the negate
				acc[2*W-1:W] <= negR ? -rem[W-1:0] : rem[W-1:0];
				acc[W-1:0]   <= negQ ? -acc[W-1:0] : acc[W-1:0];
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: aluOpPkg.sv
//////////////////////////////////////////////////
// opcodes and operation request of the ALU
// INCPC uses the free code 10011
//////////////////////////////////////////////////
`default_nettype none

`include "alu_defs.svh"

package aluOpPkg;

	// 5-bit codes, same numbering as the CPU documentation
	typedef enum logic [`ALU_OP_BITS-1:0] {
		opAdd   = 5'b00011,
		opSub   = 5'b00100,
		opShr   = 5'b00101,
		opShra  = 5'b00110,
		opShl   = 5'b00111,
		opRor   = 5'b01000,
		opRol   = 5'b01001,
		opAnd   = 5'b01010,
		opOr    = 5'b01011,
		opMul   = 5'b01111,
		opDiv   = 5'b10000,
		opNeg   = 5'b10001,
		opNot   = 5'b10010,
		opIncPc = 5'b10011
	} aluOpE;

	// one operation, 73 bits
	// neg, not and incpc work on b
	typedef struct packed {
		aluOpE                    op;
		logic [`ALU_WIDTH-1:0]    a;
		logic [`ALU_WIDTH-1:0]    b;
		logic [`ALU_TAG_BITS-1:0] tag;
	} aluReqT;

endpackage

`default_nettype wire

// File: aluPipe.sv
//////////////////////////////////////////////////
// ALU pipeline top, issue -> execute -> writeback
// latency varies, results leave in issue order
//////////////////////////////////////////////////
`default_nettype none

`include "alu_defs.svh"

module aluPipe (
	input  wire                   clk,
	input  wire                   arstN,
	input  wire                   inReq,
	input  wire aluOpPkg::aluReqT inOp,
	output logic                  inAck,
	output logic                  outReq,
	output aluResultPkg::aluRespT outResp,
	input  wire                   outAck
);

	// issue to execute
	logic                  issValid;
	logic                  issTake;
	aluOpPkg::aluReqT      issReq;

	// execute to writeback
	logic                  exValid;
	logic                  exTake;
	aluResultPkg::aluRespT exResp;

	aluIssue i_issue (
		.clk      (clk),
		.arstN    (arstN),
		.inReq    (inReq),
		.inOp     (inOp),
		.inAck    (inAck),
		.issValid (issValid),
		.issReq   (issReq),
		.issTake  (issTake)
	);

	aluExecute i_execute (
		.clk      (clk),
		.arstN    (arstN),
		.issValid (issValid),
		.issReq   (issReq),
		.issTake  (issTake),
		.exValid  (exValid),
		.exResp   (exResp),
		.exTake   (exTake)
	);

	aluWriteback i_writeback (
		.clk     (clk),
		.arstN   (arstN),
		.exValid (exValid),
		.exResp  (exResp),
		.exTake  (exTake),
		.outReq  (outReq),
		.outResp (outResp),
		.outAck  (outAck)
	);

endmodule

`default_nettype wire

// File: aluPipe_chk.sv
//////////////////////////////////////////////////
// handshake rules at the pipeline boundary
//////////////////////////////////////////////////
`default_nettype none

module aluPipeChk (
	input wire                        clk,
	input wire                        arstN,
	input wire                        inReq,
	input wire                        inAck,
	input wire                        outReq,
	input wire                        outAck,
	input wire aluResultPkg::aluRespT outResp
);

	// ack answers a request that was high on the edge before
	inAckFollowsReq: assert property (@(posedge clk) disable iff (!arstN)
		$rose(inAck) |-> $past(inReq))
		else $error("inAck rose without inReq held high");

	// response must not move while it is offered
	outRespStable: assert property (@(posedge clk) disable iff (!arstN)
		($past(outReq) && outReq) |-> $stable(outResp))
		else $error("outResp changed while outReq was high");

	// request is released only once the sink acked
	outReqAfterAck: assert property (@(posedge clk) disable iff (!arstN)
		$fell(outReq) |-> $past(outAck))
		else $error("outReq dropped before outAck");

endmodule

bind aluPipe aluPipeChk i_chk (
	.clk     (clk),
	.arstN   (arstN),
	.inReq   (inReq),
	.inAck   (inAck),
	.outReq  (outReq),
	.outAck  (outAck),
	.outResp (outResp)
);

`default_nettype wire

// File: aluResultPkg.sv
//////////////////////////////////////////////////
// result, status and multi-cycle state types
//////////////////////////////////////////////////
`default_nettype none

`include "alu_defs.svh"

package aluResultPkg;

	// the two sticky-free status bits of a response
	typedef struct packed {
		logic divZero;
		logic badOp;
	} aluStatusT;

	// execute output and top-level response, 71 bits
	// writeHi only matters between execute and writeback
	typedef struct packed {
		logic [`ALU_WIDTH-1:0]    hi;
		logic [`ALU_WIDTH-1:0]    lo;
		logic                     writeHi;
		aluStatusT                status;
		logic [`ALU_TAG_BITS-1:0] tag;
	} aluRespT;

	// multiplier/divider states
	typedef enum logic [1:0] {
		mdIdle,
		mdMul,
		mdDiv,
		mdFix
	} mdStateE;

endpackage

`default_nettype wire

// File: aluWriteback.sv
//////////////////////////////////////////////////
// HI/LO registers and four-phase output side
// one response outstanding at a time
//////////////////////////////////////////////////
`default_nettype none

`include "alu_defs.svh"

module aluWriteback (
	input  wire                        clk,
	input  wire                        arstN,
	input  wire                        exValid,
	input  wire aluResultPkg::aluRespT exResp,
	output logic                       exTake,
	output logic                       outReq,
	output aluResultPkg::aluRespT      outResp,
	input  wire                        outAck
);

	// output exchange phases
	typedef enum logic [1:0] {
		wbIdle,
		wbReq,
		wbDrain
	} wbStateE;

	wbStateE                   wbState;
	logic                      wbFire;
	logic [`ALU_WIDTH-1:0]     hiReg;
	logic [`ALU_WIDTH-1:0]     loReg;
	aluResultPkg::aluStatusT   statusReg;
	logic [`ALU_TAG_BITS-1:0]  tagReg;

	// take only once the previous exchange has fully closed
	assign exTake = (wbState == wbIdle);
	assign wbFire = exValid && exTake;
	assign outReq = (wbState == wbReq);

	// response shows the registers, writeHi is internal only
	assign outResp = {hiReg, loReg, 1'b0, statusReg, tagReg};

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbState <= wbIdle;
			hiReg   <= '0;
			loReg   <= '0;
		end else begin
			if (wbFire) begin
				loReg <= exResp.lo;
				if (exResp.writeHi)
					hiReg <= exResp.hi;
			end

			case (wbState)
				wbIdle:  if (wbFire) wbState <= wbReq;
				// sink has the data, release the request
				wbReq:   if (outAck) wbState <= wbDrain;
				// wait for ack low before the next request
				wbDrain: if (!outAck) wbState <= wbIdle;
				default: wbState <= wbIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wbFire) begin
			statusReg <= exResp.status;
			tagReg    <= exResp.tag;
		end
	end

endmodule

`default_nettype wire

// File: alu_defs.svh
//////////////////////////////////////////////////
// widths and iteration counts of the ALU pipeline
// MUL_STEPS and DIV_STEPS must follow ALU_WIDTH
//////////////////////////////////////////////////
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// operand width
`define ALU_WIDTH 32

// opcode width, codes of the CPU documentation
`define ALU_OP_BITS 5

// sequence tag carried along with each operation
`define ALU_TAG_BITS 4

// radix-4 Booth, two multiplier bits per step
`define MUL_STEPS 16

// non-restoring divide, one quotient bit per step
`define DIV_STEPS 32

`endif

// File: build.f
+incdir+.
aluOpPkg.sv
aluResultPkg.sv
aluIssue.sv
aluMulDiv.sv
aluExecute.sv
aluWriteback.sv
aluPipe.sv
aluPipe_chk.sv
tbAluPipe.sv

// File: run.sh
#!/bin/sh
# build the ALU pipeline testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tbAluPipe \
	-f build.f -o simAluPipe > build.log 2>&1 \
	|| { echo "compile failed, see build.log"; exit 1; }
./obj_dir/simAluPipe > sim.log 2>&1
cat sim.log
grep -qx 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tbAluPipe.sv
//////////////////////////////////////////////////
// random ops against a 32-bit model of HI/LO
// results are expected in issue order
//////////////////////////////////////////////////
`default_nettype none

`include "alu_defs.svh"

module tbAluPipe;

	localparam int WAIT_LIMIT = 1000;
	localparam int NUM_RANDOM = 400;
	localparam int DIRECTED   = 8;
	localparam int TOTAL      = DIRECTED + NUM_RANDOM;

	localparam logic [4:0] VALID_CODES [14] = '{
		aluOpPkg::opAdd, aluOpPkg::opSub, aluOpPkg::opShr, aluOpPkg::opShra,
		aluOpPkg::opShl, aluOpPkg::opRor, aluOpPkg::opRol, aluOpPkg::opAnd,
		aluOpPkg::opOr, aluOpPkg::opMul, aluOpPkg::opDiv, aluOpPkg::opNeg,
		aluOpPkg::opNot, aluOpPkg::opIncPc
	};
	localparam logic [4:0] BAD_CODES [8] = '{
		5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14, 5'd20, 5'd31
	};

	// corner cases first: min/-1, /0, negative dividend, extreme products
	localparam logic [4:0] DIR_CODE [DIRECTED] = '{
		aluOpPkg::opDiv, aluOpPkg::opDiv, aluOpPkg::opDiv, aluOpPkg::opMul,
		aluOpPkg::opMul, aluOpPkg::opShra, aluOpPkg::opRol, 5'b11111
	};
	localparam logic [31:0] DIR_A [DIRECTED] = '{
		32'h8000_0000, 32'h1234_5678, 32'hffff_fff9, 32'h8000_0000,
		32'h7fff_ffff, 32'h8000_0000, 32'h8000_0001, 32'h0000_00aa
	};
	localparam logic [31:0] DIR_B [DIRECTED] = '{
		32'hffff_ffff, 32'h0000_0000, 32'h0000_0002, 32'h8000_0000,
		32'h8000_0000, 32'd40, 32'd37, 32'h0000_0055
	};

	logic                  clk;
	logic                  arstN;
	logic                  inReq;
	aluOpPkg::aluReqT      inOp;
	logic                  inAck;
	logic                  outReq;
	aluResultPkg::aluRespT outResp;
	logic                  outAck;

	logic [31:0]                stimState;
	logic [31:0]                ackState;
	logic [`ALU_WIDTH-1:0]      modelHi;
	logic [`ALU_WIDTH-1:0]      modelLo;
	logic [`ALU_TAG_BITS-1:0]   nextTag;
	aluResultPkg::aluRespT      expQ[$];
	int                         checkCount;
	int                         errCount;
	int                         timeoutCount;
	logic                       aborted;

	aluPipe i_dut (
		.clk     (clk),
		.arstN   (arstN),
		.inReq   (inReq),
		.inOp    (inOp),
		.inAck   (inAck),
		.outReq  (outReq),
		.outResp (outResp),
		.outAck  (outAck)
	);

	always #2 clk = ~clk;

	// two LCG streams so stimulus and ack delays don't interfere
	function automatic logic [31:0] stimRand();
		stimState = stimState * 32'd1664525 + 32'd1013904223;
		return stimState;
	endfunction

	function automatic logic [31:0] ackRand();
		ackState = ackState * 32'd1664525 + 32'd1013904223;
		return ackState;
	endfunction

	// mostly random, sometimes an extreme value
	function automatic logic [31:0] pickOperand();
		logic [31:0] r;
		logic [31:0] val;
		r = stimRand();
		case (r[31:29])
			3'd0:    val = 32'h8000_0000;
			3'd1:    val = 32'h7fff_ffff;
			3'd2:    val = 32'hffff_ffff;
			3'd3:    val = {24'h0, r[15:8]};
			default: val = stimRand();
		endcase
		return val;
	endfunction

	task automatic compareField(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checkCount++;
		assert (got === exp) else begin
			errCount++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// reference behavior, HI/LO follow issue order
	task automatic modelOp(input aluOpPkg::aluReqT req);
		aluResultPkg::aluRespT exp;
		logic [31:0]           a;
		logic [31:0]           b;
		logic [4:0]            s;
		longint                sa;
		longint                sb;
		longint                quo;
		longint                rm;
		logic [63:0]           prod;
		a   = req.a;
		b   = req.b;
		s   = b[4:0];
		sa  = longint'($signed(a));
		sb  = longint'($signed(b));
		exp = '0;
		exp.tag = req.tag;
		case (req.op)
			aluOpPkg::opAdd:   modelLo = a + b;
			aluOpPkg::opSub:   modelLo = a - b;
			aluOpPkg::opAnd:   modelLo = a & b;
			aluOpPkg::opOr:    modelLo = a | b;
			aluOpPkg::opNeg:   modelLo = 32'd0 - b;
			aluOpPkg::opNot:   modelLo = ~b;
			aluOpPkg::opIncPc: modelLo = b + 32'd1;
			aluOpPkg::opShr:   modelLo = (b > 31) ? 32'h0 : (a >> s);
			aluOpPkg::opShl:   modelLo = (b > 31) ? 32'h0 : (a << s);
			aluOpPkg::opShra: begin
				if (b > 31)
					modelLo = {32{a[31]}};
				else
					modelLo = (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'h0);
			end
			aluOpPkg::opRor:   modelLo = (a >> s) | (a << (32 - s));
			aluOpPkg::opRol:   modelLo = (a << s) | (a >> (32 - s));
			aluOpPkg::opMul: begin
				prod    = sa * sb;
				modelHi = prod[63:32];
				modelLo = prod[31:0];
			end
			aluOpPkg::opDiv: begin
				if (b == 32'h0) begin
					exp.status.divZero = 1'b1;
					modelHi = a;
					modelLo = 32'h0;
				end else begin
					// 64-bit math so min / -1 wraps in the low half
					quo     = sa / sb;
					rm      = sa % sb;
					modelHi = rm[31:0];
					modelLo = quo[31:0];
				end
			end
			default: begin
				exp.status.badOp = 1'b1;
				modelLo = 32'h0;
			end
		endcase
		exp.hi = modelHi;
		exp.lo = modelLo;
		expQ.push_back(exp);
	endtask

	task automatic issueOp(input logic [4:0] code, input logic [31:0] a,
			input logic [31:0] b);
		aluOpPkg::aluReqT req;
		int               waited;
		req.op  = aluOpPkg::aluOpE'(code);
		req.a   = a;
		req.b   = b;
		req.tag = nextTag;
		modelOp(req);
		nextTag = nextTag + 1'b1;
		inOp    = req;
		inReq   = 1'b1;
		waited  = 0;
		while (!inAck && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		assert (inAck) else begin
			timeoutCount++;
			aborted = 1'b1;
			$display("%0t timeout, inAck never rose for tag %0d", $time, req.tag);
		end
		inReq  = 1'b0;
		waited = 0;
		while (inAck && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		assert (!inAck) else begin
			timeoutCount++;
			aborted = 1'b1;
			$display("%0t timeout, inAck stuck high after inReq dropped", $time);
		end
	endtask

	task automatic makeRandomOp(output logic [4:0] code, output logic [31:0] a,
			output logic [31:0] b);
		logic [31:0] r;
		r = stimRand();
		if (r[31:28] < 4'd14)
			code = VALID_CODES[r[31:28]];
		else
			code = BAD_CODES[r[26:24]];
		a = pickOperand();
		b = pickOperand();
		case (code)
			aluOpPkg::opShr, aluOpPkg::opShra, aluOpPkg::opShl,
			aluOpPkg::opRor, aluOpPkg::opRol:
				b = (stimRand() >> 16) % 41;
			aluOpPkg::opDiv: begin
				r = stimRand();
				if (r[31:29] == 3'd0) begin
					b = 32'h0;
				end else if (r[31:29] == 3'd1) begin
					a = 32'h8000_0000;
					b = 32'hffff_ffff;
				end
			end
			default: ;
		endcase
	endtask

	task automatic driveStimulus();
		logic [4:0]  code;
		logic [31:0] a;
		logic [31:0] b;
		int          gap;
		for (int n = 0; n < DIRECTED && !aborted; n++)
			issueOp(DIR_CODE[n], DIR_A[n], DIR_B[n]);
		for (int n = 0; n < NUM_RANDOM && !aborted; n++) begin
			makeRandomOp(code, a, b);
			gap = int'(stimRand() >> 30);
			repeat (gap) @(negedge clk);
			issueOp(code, a, b);
		end
	endtask

	// sink side, random ack delay gives back-pressure
	task automatic collectResponses();
		aluResultPkg::aluRespT exp;
		logic [31:0]           r;
		int                    waited;
		int                    delay;
		for (int n = 0; n < TOTAL && !aborted; n++) begin
			waited = 0;
			while (!outReq && waited < WAIT_LIMIT) begin
				@(negedge clk);
				waited++;
			end
			assert (outReq) else begin
				timeoutCount++;
				aborted = 1'b1;
				$display("%0t timeout, response %0d never offered", $time, n);
			end
			if (aborted)
				break;
			assert (expQ.size() > 0) else begin
				errCount++;
				$display("%0t response with tag %0d arrived with none expected",
					$time, outResp.tag);
			end
			if (expQ.size() > 0) begin
				exp = expQ.pop_front();
				compareField("outResp.tag", outResp.tag, exp.tag);
				compareField("outResp.lo", outResp.lo, exp.lo);
				compareField("outResp.hi", outResp.hi, exp.hi);
				compareField("outResp.writeHi", outResp.writeHi, exp.writeHi);
				compareField("outResp.status.divZero", outResp.status.divZero,
					exp.status.divZero);
				compareField("outResp.status.badOp", outResp.status.badOp,
					exp.status.badOp);
			end
			r     = ackRand();
			delay = r[28] ? int'(r[31:29]) * 3 : int'(r[31:30]);
			repeat (delay) @(negedge clk);
			outAck = 1'b1;
			waited = 0;
			while (outReq && waited < WAIT_LIMIT) begin
				@(negedge clk);
				waited++;
			end
			assert (!outReq) else begin
				timeoutCount++;
				aborted = 1'b1;
				$display("%0t timeout, outReq stayed high after outAck", $time);
			end
			outAck = 1'b0;
		end
	endtask

	initial begin
		clk          = 1'b0;
		arstN        = 1'b0;
		inReq        = 1'b0;
		inOp         = '0;
		outAck       = 1'b0;
		stimState    = 32'hf452_b8d3;
		ackState     = ~32'hf452_b8d3;
		modelHi      = '0;
		modelLo      = '0;
		nextTag      = '0;
		checkCount   = 0;
		errCount     = 0;
		timeoutCount = 0;
		aborted      = 1'b0;
		repeat (10) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);

		fork
			driveStimulus();
			collectResponses();
		join

		// nothing left over, nothing extra
		assert (expQ.size() == 0) else begin
			errCount++;
			$display("%0d expected responses never arrived", expQ.size());
		end
		if (!aborted) begin
			repeat (20) begin
				@(negedge clk);
				assert (!outReq) else begin
					errCount++;
					$display("%0t extra response after the last one, tag %0d",
						$time, outResp.tag);
				end
			end
		end

		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errCount,
			timeoutCount);
		if (errCount == 0 && timeoutCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire
